// ==== rv_core.f ====
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_core.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=rv_core_tb
LOG=sim.log

verilator --binary --timing -Wno-fatal -f rv_core.f --top-module "$TOP" -o "V$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_core_tb;

	localparam int PAD   = 3; // Bubble words after each program
	localparam int NRAND = 40;

	logic                   clk = 1'b0;
	logic                   rstn;
	logic                   run_i;
	logic                   imem_we_i;
	logic [`RV_IMEM_AW-1:0] imem_addr_i;
	logic [`RV_XLEN-1:0]    imem_data_i;
	logic                   wb_valid_o;
	logic [4:0]             wb_rd_o;
	logic [`RV_XLEN-1:0]    wb_data_o;
	logic                   test_end;
	logic [2:0][4:0]        exp_rd;
	logic [2:0][31:0]       exp_val;
	int                     err_cnt;
	int                     pass_cnt = 0;
	int                     fail_cnt = 0;
	int                     seed;
	int                     row_start = 0;
	logic                   table_ready = 1'b0;

	// Stimulus table, three expected registers per row
	string       name_tab [$];
	int          start_tab [$];
	int          len_tab [$];
	int          pause_tab [$];
	logic [4:0]  chk_rd_tab [$];
	logic [31:0] chk_val_tab [$];
	logic [31:0] prog [$];

	always #5 clk = ~clk;

	rv_core dut (
		.clk(clk), .rstn(rstn), .run_i(run_i),
		.imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
		.wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
	);

	rv_core_checker chk (
		.clk(clk), .rstn(rstn), .run_i(run_i),
		.imem_we_i(imem_we_i), .imem_addr_i(imem_addr_i), .imem_data_i(imem_data_i),
		.wb_valid_i(wb_valid_o), .wb_rd_i(wb_rd_o), .wb_data_i(wb_data_o),
		.test_end_i(test_end), .exp_rd_i(exp_rd), .exp_val_i(exp_val), .err_cnt_o(err_cnt)
	);

	function automatic logic [31:0] op_word(input int f7, input int rs2, input int rs1,
			input int f3, input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
	endfunction

	function automatic logic [31:0] imm_word(input int imm, input int rs1, input int f3,
			input int rd);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
	endfunction

	function automatic logic [31:0] lui_word(input int imm, input int rd);
		return {imm[19:0], rd[4:0], 7'h37};
	endfunction

	function automatic void add_row(input string name, input int pause, input int rd0,
			input int v0, input int rd1, input int v1, input int rd2, input int v2);
		name_tab.push_back(name);
		start_tab.push_back(row_start);
		len_tab.push_back(prog.size() - row_start);
		pause_tab.push_back(pause);
		chk_rd_tab.push_back(rd0[4:0]);
		chk_rd_tab.push_back(rd1[4:0]);
		chk_rd_tab.push_back(rd2[4:0]);
		chk_val_tab.push_back(v0);
		chk_val_tab.push_back(v1);
		chk_val_tab.push_back(v2);
		row_start = prog.size();
	endfunction

	// Supported instructions only, registers x0 to x7
	function automatic logic [31:0] random_word();
		logic [31:0] r;
		logic [31:0] s;
		logic [2:0]  f3;
		logic [31:0] w;
		r  = $random(seed);
		s  = $random(seed);
		f3 = (r[4:2] == 3'b011) ? 3'b000 : r[4:2];
		if (r[1:0] == 2'd3)
			w = lui_word(int'(r[31:12]), int'(s[2:0]));
		else if (r[1:0] == 2'd2 && (f3 == 3'b001 || f3 == 3'b101))
			w = imm_word(int'(r[24:20]), int'(s[5:3]), int'(f3), int'(s[2:0]));
		else if (r[1:0] == 2'd2)
			w = imm_word(int'(r[31:20]), int'(s[5:3]), int'(f3), int'(s[2:0]));
		else
			w = op_word((f3 == 3'b000 && r[5]) ? 32 : 0, int'(s[8:6]), int'(s[5:3]),
				int'(f3), int'(s[2:0]));
		return w;
	endfunction

	task automatic build_programs();
		prog.push_back(imm_word(100, 0, 0, 1));
		prog.push_back(imm_word(-7, 0, 0, 2));
		prog.push_back(imm_word(12'h5a5, 0, 0, 9));
		prog.push_back(op_word(0, 2, 1, 0, 3));
		prog.push_back(op_word(32, 1, 2, 0, 4));
		prog.push_back(op_word(0, 9, 1, 7, 5));
		prog.push_back(op_word(0, 9, 1, 6, 6));
		prog.push_back(op_word(0, 9, 1, 4, 7));
		prog.push_back(op_word(0, 1, 2, 2, 8)); // -7 < 100
		prog.push_back(op_word(0, 2, 1, 2, 10));
		add_row("alu_basic", 0, 4, 32'hffffff95, 7, 32'h5c1, 8, 1);
		prog.push_back(imm_word(1, 0, 0, 1));
		prog.push_back(op_word(0, 1, 1, 0, 1));
		prog.push_back(op_word(0, 1, 1, 0, 1));
		prog.push_back(imm_word(3, 1, 0, 1));
		prog.push_back(imm_word(10, 0, 0, 2));
		prog.push_back(imm_word(20, 0, 0, 3));
		prog.push_back(op_word(0, 1, 2, 0, 4));
		prog.push_back(op_word(32, 4, 3, 0, 5));
		prog.push_back(op_word(0, 4, 5, 0, 6));
		prog.push_back(imm_word(6, 6, 0, 7)); // Immediate bits alias rs2 = x6
		add_row("fwd_chain", 0, 5, 3, 6, 32'h14, 7, 32'h1a);
		prog.push_back(lui_word(20'h12345, 1));
		prog.push_back(imm_word(12'h678, 1, 0, 1));
		prog.push_back(lui_word(20'hdeadc, 2));
		prog.push_back(imm_word(-273, 2, 0, 2));
		prog.push_back(imm_word(4, 1, 1, 3));
		prog.push_back(imm_word(8, 2, 5, 4));
		prog.push_back(imm_word(36, 0, 0, 5));
		prog.push_back(op_word(0, 5, 1, 1, 6));
		prog.push_back(op_word(0, 5, 2, 5, 7));
		add_row("lui_shift", 0, 4, 32'h00deadbe, 6, 32'h23456780, 7, 32'h0deadbee);
		prog.push_back(imm_word(5, 0, 0, 0));
		prog.push_back(imm_word(1, 0, 0, 6));
		prog.push_back(32'hffffffff);
		prog.push_back(imm_word(1, 0, 3, 1)); // SLTIU
		prog.push_back(imm_word(12'h401, 0, 5, 2)); // SRAI
		prog.push_back(op_word(32, 3, 3, 5, 7)); // SRA
		prog.push_back(imm_word(7, 0, 0, 3));
		prog.push_back(op_word(0, 3, 0, 0, 4));
		add_row("x0_illegal", 0, 1, 0, 4, 7, 6, 1);
		prog.push_back(imm_word(3, 0, 0, 1));
		prog.push_back(imm_word(5, 0, 0, 2));
		prog.push_back(op_word(0, 2, 1, 0, 3));
		prog.push_back(op_word(32, 1, 3, 0, 4));
		prog.push_back(imm_word(255, 4, 4, 5));
		prog.push_back(imm_word(256, 5, 6, 6));
		prog.push_back(imm_word(240, 6, 7, 7));
		prog.push_back(imm_word(-1, 7, 2, 8));
		add_row("run_pause", 3, 4, 5, 6, 32'h1fa, 7, 32'hf0);
	endtask

	task automatic load_program(input int start, input int len);
		for (int i = 0; i < len + PAD; i++) begin
			imem_we_i   = 1'b1;
			imem_addr_i = i[`RV_IMEM_AW-1:0];
			imem_data_i = (i < len) ? prog[start + i] : 32'h0; // Zero word is a bubble
			@(negedge clk);
		end
		imem_we_i = 1'b0;
	endtask

	task automatic run_row(input int t);
		int errs_before;
		errs_before = err_cnt;
		for (int k = 0; k < 3; k++) begin
			exp_rd[k]  = chk_rd_tab[3*t + k];
			exp_val[k] = chk_val_tab[3*t + k];
		end
		run_i = 1'b0;
		rstn  = 1'b0;
		repeat (3) @(negedge clk);
		rstn = 1'b1;
		load_program(start_tab[t], len_tab[t]);
		run_i = 1'b1;
		if (pause_tab[t] > 0) begin
			repeat (pause_tab[t]) @(negedge clk);
			run_i = 1'b0;
			repeat (4) @(negedge clk);
			run_i = 1'b1;
			repeat (len_tab[t] + PAD - pause_tab[t]) @(negedge clk);
		end else begin
			repeat (len_tab[t] + PAD) @(negedge clk);
		end
		run_i = 1'b0;
		repeat (3) @(negedge clk); // Drain
		test_end = 1'b1;
		@(negedge clk);
		test_end = 1'b0;
		if (err_cnt == errs_before) begin
			pass_cnt++;
			$display("Test %0d %s: PASS", t, name_tab[t]);
		end else begin
			fail_cnt++;
			$display("Test %0d %s: FAIL with %0d errors", t, name_tab[t], err_cnt - errs_before);
		end
	endtask

	initial begin : watchdog
		int limit;
		wait (table_ready);
		limit = 50;
		for (int t = 0; t < name_tab.size(); t++)
			limit += 2 * (len_tab[t] + PAD) + 16;
		repeat (limit) @(posedge clk);
		$display("Simulation timed out after %0d cycles", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		rstn        = 1'b0;
		run_i       = 1'b0;
		imem_we_i   = 1'b0;
		imem_addr_i = '0;
		imem_data_i = '0;
		test_end    = 1'b0;
		exp_rd      = '0;
		exp_val     = '0;
		seed        = 32'h843a;
		build_programs();
		for (int i = 0; i < NRAND; i++)
			prog.push_back(random_word());
		add_row("random", 0, 0, 0, 0, 0, 0, 0);
		table_ready = 1'b1;
		for (int t = 0; t < name_tab.size(); t++)
			run_row(t);
		$display("Tests: %0d, passed %0d, failed %0d, errors %0d",
			name_tab.size(), pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== verif/rv_core_checker.sv ====
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_core_checker import rv_isa_pkg::*; (
	input  logic                     clk,
	input  logic                     rstn,
	input  logic                     run_i,
	input  logic                     imem_we_i,
	input  logic [`RV_IMEM_AW-1:0]   imem_addr_i,
	input  logic [`RV_XLEN-1:0]      imem_data_i,
	input  logic                     wb_valid_i,
	input  logic [4:0]               wb_rd_i,
	input  logic [`RV_XLEN-1:0]      wb_data_i,
	input  logic                     test_end_i,
	input  logic [2:0][4:0]          exp_rd_i,
	input  logic [2:0][`RV_XLEN-1:0] exp_val_i,
	output int                       err_cnt_o
);

	instr_u                 mem [2**`RV_IMEM_AW];
	logic [`RV_XLEN-1:0]    ref_regs [`RV_NREGS];
	logic [`RV_XLEN-1:0]    dut_regs [`RV_NREGS]; // As seen on the retire port
	logic [`RV_IMEM_AW-1:0] pc;
	logic [4:0]             rd_q [$];
	logic [`RV_XLEN-1:0]    data_q [$];
	int                     due_q [$];
	int                     cyc;
	logic [`RV_XLEN-1:0]    res;
	logic                   writes;
	int                     errs = 0;

	assign err_cnt_o = errs;

	// Returns 1 when the word writes a nonzero rd, result in y
	function automatic logic execute_word(input instr_u w, output logic [`RV_XLEN-1:0] y);
		logic [`RV_XLEN-1:0] a;
		logic [`RV_XLEN-1:0] b;
		logic                wr;
		a  = ref_regs[w.r_fmt.rs1];
		b  = ref_regs[w.r_fmt.rs2];
		wr = 1'b1;
		y  = '0;
		if (w.r_fmt.opcode == OPC_OP_IMM)
			b = {{20{w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
		if (w.r_fmt.opcode == OPC_LUI) begin
			y = {w[31:12], 12'h000};
		end else if (w.r_fmt.opcode == OPC_OP || w.r_fmt.opcode == OPC_OP_IMM) begin
			case (w.r_fmt.funct3)
				F3_ADD_SUB: y = (w.r_fmt.opcode == OPC_OP && w.r_fmt.funct7 == 7'h20) ? a - b : a + b;
				F3_SLL:     y = a << b[4:0];
				F3_SLT:     y = ($signed(a) < $signed(b)) ? 1 : 0;
				F3_XOR:     y = a ^ b;
				F3_SRL:     y = a >> b[4:0];
				F3_OR:      y = a | b;
				F3_AND:     y = a & b;
				default:    wr = 1'b0; // SLTU, SLTIU
			endcase
			if (w.r_fmt.opcode == OPC_OP && w.r_fmt.funct7 != 7'h00 &&
					!(w.r_fmt.funct7 == 7'h20 && w.r_fmt.funct3 == F3_ADD_SUB))
				wr = 1'b0;
			if (w.r_fmt.opcode == OPC_OP_IMM && w.r_fmt.funct7 != 7'h00 &&
					(w.r_fmt.funct3 == F3_SLL || w.r_fmt.funct3 == F3_SRL))
				wr = 1'b0; // SRAI and bad shift amounts
		end else begin
			wr = 1'b0;
		end
		return wr && (w.r_fmt.rd != 5'd0);
	endfunction

	always @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			pc  = `RV_IMEM_AW'(`RV_RESET_PC);
			cyc = 0;
			for (int i = 0; i < `RV_NREGS; i++) begin
				ref_regs[i] = '0;
				dut_regs[i] = '0;
			end
			rd_q.delete();
			data_q.delete();
			due_q.delete();
		end else begin
			cyc = cyc + 1;
			if (imem_we_i)
				mem[imem_addr_i] = imem_data_i;
			if (wb_valid_i) begin
				if (rd_q.size() == 0) begin
					$display("Unexpected write of %h to x%0d with nothing due to retire",
						wb_data_i, wb_rd_i);
					errs++;
				end else begin
					if (wb_rd_i !== rd_q[0]) begin
						$display("** Error: wb_rd_o expected %h, got %h", rd_q[0], wb_rd_i);
						errs++;
					end
					if (wb_data_i !== data_q[0]) begin
						$display("** Error: wb_data_o expected %h, got %h", data_q[0], wb_data_i);
						errs++;
					end
					if (cyc != due_q[0]) begin
						$display("Write to x%0d retired %0d cycles after its fetch, not 3",
							wb_rd_i, cyc - due_q[0] + 3);
						errs++;
					end
					void'(rd_q.pop_front());
					void'(data_q.pop_front());
					void'(due_q.pop_front());
				end
				dut_regs[wb_rd_i] = wb_data_i;
			end
			if (run_i) begin // Fetch edge, model runs in PC order
				writes = execute_word(mem[pc], res);
				if (writes) begin
					rd_q.push_back(mem[pc].r_fmt.rd);
					data_q.push_back(res);
					due_q.push_back(cyc + 3); // Seen on the retire port three edges on
					ref_regs[mem[pc].r_fmt.rd] = res;
				end
				pc = pc + `RV_IMEM_AW'(1);
			end
			if (test_end_i) begin
				if (rd_q.size() != 0) begin
					$display("%0d expected register writes never retired", rd_q.size());
					errs++;
				end
				for (int k = 0; k < 3; k++) begin
					if (exp_rd_i[k] != 5'd0 && dut_regs[exp_rd_i[k]] !== exp_val_i[k]) begin
						$display("** Error: x%0d expected %h, got %h", exp_rd_i[k],
							exp_val_i[k], dut_regs[exp_rd_i[k]]);
						errs++;
					end
				end
			end
		end
	end

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_core (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic                         run_i,
	input  logic                         imem_we_i,
	input  logic [`RV_IMEM_AW-1:0]       imem_addr_i,
	input  logic [`RV_XLEN-1:0]          imem_data_i,
	output logic                         wb_valid_o,
	output logic [$clog2(`RV_NREGS)-1:0] wb_rd_o,
	output logic [`RV_XLEN-1:0]          wb_data_o
);

	localparam int RAW = $clog2(`RV_NREGS);

	logic                f_valid;
	logic [`RV_XLEN-1:0] f_instr;

	logic                d_valid;
	logic [3:0]          d_alu_op;
	logic [RAW-1:0]      d_rd;
	logic [RAW-1:0]      d_rs1;
	logic [RAW-1:0]      d_rs2;
	logic [`RV_XLEN-1:0] d_op_a;
	logic [`RV_XLEN-1:0] d_op_b;
	logic                d_use_rs2;

	logic                wr_en;
	logic [RAW-1:0]      wr_addr;
	logic [`RV_XLEN-1:0] wr_data;

	rv_fetch u_fetch (
		.clk         (clk),
		.rstn        (rstn),
		.run_i       (run_i),
		.imem_we_i   (imem_we_i),
		.imem_addr_i (imem_addr_i),
		.imem_data_i (imem_data_i),
		.f_valid_o   (f_valid),
		.f_instr_o   (f_instr)
	);

	rv_decode u_decode (
		.clk         (clk),
		.rstn        (rstn),
		.f_valid_i   (f_valid),
		.f_instr_i   (f_instr),
		.wr_en_i     (wr_en),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data),
		.d_valid_o   (d_valid),
		.d_alu_op_o  (d_alu_op),
		.d_rd_o      (d_rd),
		.d_rs1_o     (d_rs1),
		.d_rs2_o     (d_rs2),
		.d_op_a_o    (d_op_a),
		.d_op_b_o    (d_op_b),
		.d_use_rs2_o (d_use_rs2)
	);

	rv_execute u_execute (
		.clk         (clk),
		.rstn        (rstn),
		.d_valid_i   (d_valid),
		.d_alu_op_i  (d_alu_op),
		.d_rd_i      (d_rd),
		.d_rs1_i     (d_rs1),
		.d_rs2_i     (d_rs2),
		.d_op_a_i    (d_op_a),
		.d_op_b_i    (d_op_b),
		.d_use_rs2_i (d_use_rs2),
		.wr_en_o     (wr_en),
		.wr_addr_o   (wr_addr),
		.wr_data_o   (wr_data)
	);

	// Retirement mirrors the register file write
	assign wb_valid_o = wr_en;
	assign wb_rd_o    = wr_addr;
	assign wb_data_o  = wr_data;

endmodule

// ==== verilog/rv_execute.sv ====
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_execute import rv_pipe_pkg::*; (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic                         d_valid_i,
	input  logic [3:0]                   d_alu_op_i,
	input  logic [$clog2(`RV_NREGS)-1:0] d_rd_i,
	input  logic [$clog2(`RV_NREGS)-1:0] d_rs1_i,
	input  logic [$clog2(`RV_NREGS)-1:0] d_rs2_i,
	input  logic [`RV_XLEN-1:0]          d_op_a_i,
	input  logic [`RV_XLEN-1:0]          d_op_b_i,
	input  logic                         d_use_rs2_i,
	output logic                         wr_en_o,
	output logic [$clog2(`RV_NREGS)-1:0] wr_addr_o,
	output logic [`RV_XLEN-1:0]          wr_data_o
);

	alu_op_e             alu_op;
	fwd_sel_e            sel_a;
	fwd_sel_e            sel_b;
	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] result;

	assign alu_op = alu_op_e'(d_alu_op_i);

	// wr_en_o already implies a valid result with nonzero rd
	assign sel_a = (wr_en_o && wr_addr_o == d_rs1_i) ? FWD_RES : FWD_DEC;
	assign sel_b = (d_use_rs2_i && wr_en_o && wr_addr_o == d_rs2_i) ? FWD_RES : FWD_DEC;

	assign op_a = (sel_a == FWD_RES) ? wr_data_o : d_op_a_i;
	assign op_b = (sel_b == FWD_RES) ? wr_data_o : d_op_b_i;

	always_comb begin
		case (alu_op)
			ALU_ADD:    result = op_a + op_b;
			ALU_SUB:    result = op_a - op_b;
			ALU_AND:    result = op_a & op_b;
			ALU_OR:     result = op_a | op_b;
			ALU_XOR:    result = op_a ^ op_b;
			ALU_SLT:    result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLL:    result = op_a << op_b[4:0];
			ALU_SRL:    result = op_a >> op_b[4:0];
			ALU_PASS_B: result = op_b;
			default:    result = '0;
		endcase
	end

	// Result register, also the register file write port
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			wr_en_o <= 1'b0;
		end else begin
			wr_en_o <= d_valid_i && (d_rd_i != '0); // x0 writes dropped
		end
	end

	always_ff @(posedge clk) begin
		wr_addr_o <= d_rd_i;
		wr_data_o <= result;
	end

endmodule

// ==== verilog/rv_decode.sv ====
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_decode import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic                         clk,
	input  logic                         rstn,
	input  logic                         f_valid_i,
	input  instr_u                       f_instr_i,
	input  logic                         wr_en_i,
	input  logic [$clog2(`RV_NREGS)-1:0] wr_addr_i,
	input  logic [`RV_XLEN-1:0]          wr_data_i,
	output logic                         d_valid_o,
	output logic [3:0]                   d_alu_op_o,
	output logic [$clog2(`RV_NREGS)-1:0] d_rd_o,
	output logic [$clog2(`RV_NREGS)-1:0] d_rs1_o,
	output logic [$clog2(`RV_NREGS)-1:0] d_rs2_o,
	output logic [`RV_XLEN-1:0]          d_op_a_o,
	output logic [`RV_XLEN-1:0]          d_op_b_o,
	output logic                         d_use_rs2_o
);

	localparam int RAW = $clog2(`RV_NREGS);

	alu_op_e             alu_op;
	logic                supported;
	logic                use_rs2;
	logic [`RV_XLEN-1:0] imm;
	logic [RAW-1:0]      rs1;
	logic [RAW-1:0]      rs2;
	logic [RAW-1:0]      rd;
	logic [`RV_XLEN-1:0] rs1_val;
	logic [`RV_XLEN-1:0] rs2_val;
	logic [`RV_XLEN-1:0] regs [`RV_NREGS];

	assign rs1 = f_instr_i.r_fmt.rs1;
	assign rs2 = f_instr_i.r_fmt.rs2;
	assign rd  = f_instr_i.r_fmt.rd;

	always_comb begin
		alu_op    = ALU_ADD;
		supported = 1'b0;
		use_rs2   = 1'b0;
		imm       = {{(`RV_XLEN-12){f_instr_i.i_fmt.imm12[11]}}, f_instr_i.i_fmt.imm12};
		case (f_instr_i.r_fmt.opcode)
			OPC_OP: begin
				use_rs2 = 1'b1;
				if (f_instr_i.r_fmt.funct7 == 7'h00) begin
					supported = 1'b1;
					case (f_instr_i.r_fmt.funct3)
						F3_ADD_SUB: alu_op = ALU_ADD;
						F3_SLL:     alu_op = ALU_SLL;
						F3_SLT:     alu_op = ALU_SLT;
						F3_XOR:     alu_op = ALU_XOR;
						F3_SRL:     alu_op = ALU_SRL;
						F3_OR:      alu_op = ALU_OR;
						F3_AND:     alu_op = ALU_AND;
						default:    supported = 1'b0; // SLTU
					endcase
				end else if (f_instr_i.r_fmt.funct7 == 7'h20 &&
						f_instr_i.r_fmt.funct3 == F3_ADD_SUB) begin
					supported = 1'b1;
					alu_op    = ALU_SUB;
				end
			end
			OPC_OP_IMM: begin
				supported = 1'b1;
				case (f_instr_i.i_fmt.funct3)
					F3_ADD_SUB: alu_op = ALU_ADD;
					F3_SLT:     alu_op = ALU_SLT;
					F3_XOR:     alu_op = ALU_XOR;
					F3_OR:      alu_op = ALU_OR;
					F3_AND:     alu_op = ALU_AND;
					F3_SLL: begin
						alu_op    = ALU_SLL;
						imm       = {{(`RV_XLEN-5){1'b0}}, f_instr_i.i_fmt.imm12[4:0]};
						supported = (f_instr_i.i_fmt.imm12[11:5] == 7'h00);
					end
					F3_SRL: begin
						alu_op    = ALU_SRL;
						imm       = {{(`RV_XLEN-5){1'b0}}, f_instr_i.i_fmt.imm12[4:0]};
						supported = (f_instr_i.i_fmt.imm12[11:5] == 7'h00); // SRAI excluded
					end
					default: supported = 1'b0; // SLTIU
				endcase
			end
			OPC_LUI: begin
				supported = 1'b1;
				alu_op    = ALU_PASS_B;
				imm       = {f_instr_i.i_fmt.imm12, f_instr_i.i_fmt.rs1,
						f_instr_i.i_fmt.funct3, 12'h000};
			end
			default: supported = 1'b0;
		endcase
	end

	// Same-cycle bypass from the write port
	always_comb begin
		if (rs1 == '0)
			rs1_val = '0;
		else if (wr_en_i && wr_addr_i == rs1)
			rs1_val = wr_data_i;
		else
			rs1_val = regs[rs1];

		if (rs2 == '0)
			rs2_val = '0;
		else if (wr_en_i && wr_addr_i == rs2)
			rs2_val = wr_data_i;
		else
			rs2_val = regs[rs2];
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < `RV_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i && wr_addr_i != '0) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			d_valid_o <= 1'b0;
			d_rd_o    <= '0;
		end else begin
			d_valid_o <= f_valid_i & supported;
			d_rd_o    <= (f_valid_i && supported) ? rd : '0; // No target for bubbles
		end
	end

	always_ff @(posedge clk) begin
		d_alu_op_o  <= alu_op;
		d_rs1_o     <= rs1;
		d_rs2_o     <= rs2;
		d_op_a_o    <= rs1_val;
		d_op_b_o    <= use_rs2 ? rs2_val : imm;
		d_use_rs2_o <= use_rs2;
	end

endmodule

// ==== verilog/rv_fetch.sv ====
`timescale 1ns/100ps
`include "rv_core_defs.svh"

module rv_fetch import rv_isa_pkg::*; (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   run_i,
	input  logic                   imem_we_i,
	input  logic [`RV_IMEM_AW-1:0] imem_addr_i,
	input  logic [`RV_XLEN-1:0]    imem_data_i,
	output logic                   f_valid_o,
	output instr_u                 f_instr_o
);

	instr_u                 imem [2**`RV_IMEM_AW];
	logic [`RV_IMEM_AW-1:0] pc;

	// Program load port
	always_ff @(posedge clk) begin
		if (imem_we_i) begin
			imem[imem_addr_i] <= imem_data_i;
		end
	end

	// PC wraps at the top of the memory
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			pc        <= `RV_IMEM_AW'(`RV_RESET_PC);
			f_valid_o <= 1'b0;
		end else begin
			f_valid_o <= run_i;
			if (run_i) begin
				pc <= pc + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (run_i) begin
			f_instr_o <= imem[pc]; // Held while stopped
		end
	end

endmodule

// ==== verilog/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

	// Operations carried from decode to execute
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B // LUI
	} alu_op_e;

	// Operand source in execute
	typedef enum logic {
		FWD_DEC, // Value read in decode
		FWD_RES  // Result register
	} fwd_sel_e;

endpackage

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	// funct3 groups shared by OP and OP_IMM
	typedef enum logic [2:0] {
		F3_ADD_SUB = 3'b000,
		F3_SLL     = 3'b001,
		F3_SLT     = 3'b010,
		F3_XOR     = 3'b100,
		F3_SRL     = 3'b101,
		F3_OR      = 3'b110,
		F3_AND     = 3'b111
	} funct3_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_e    funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		funct3_e     funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	// One instruction word, seen as register or immediate form
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

endpackage

// ==== verilog/rv_core_defs.svh ====
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// Data and instruction word width
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_NREGS 32

// Instruction memory address width in words (64 words)
`define RV_IMEM_AW 6

// Word address of the first fetch after reset
`define RV_RESET_PC 0

`endif
